/* src/cpu_pkg.sv */
package cpu_pkg;

    // -------------------------------------------------------------------------
    // sizes and address map
    // -------------------------------------------------------------------------
    localparam int XLEN            = 32;
    localparam int IMEM_AW         = 8;
    localparam int DMEM_AW         = 8;
    localparam int DEBOUNCE_CYCLES = 8;

    // everything from here up is I/O, below is data memory
    localparam logic [XLEN-1:0] IO_BASE  = 32'h0000_F000;
    localparam logic [XLEN-1:0] SW_ADDR  = IO_BASE + 32'h0;
    localparam logic [XLEN-1:0] LED_ADDR = IO_BASE + 32'h4;

    // the only SYSTEM encoding that does anything
    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

    // -------------------------------------------------------------------------
    // encodings
    // -------------------------------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        PROGRAM,
        RUN,
        HALT
    } run_state_e;

    // -------------------------------------------------------------------------
    // bundles
    // -------------------------------------------------------------------------
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    wb_pc4;
        logic    ebreak;
    } ctrl_t;

    // word write from the boot loader side
    typedef struct packed {
        logic               we;
        logic [IMEM_AW-1:0] addr;
        logic [XLEN-1:0]    data;
    } prog_wr_t;

    typedef struct packed {
        logic            running;
        logic            halted;
        logic [XLEN-1:0] pc;
    } cpu_status_t;

endpackage

/* src/key_debounce.sv */
`timescale 1ns/1ps

module key_debounce (
    input  logic clk,
    input  logic rstn_fpga,
    input  logic key_i,
    output logic press_o
);

    import cpu_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);

    logic             key_meta;
    logic             key_sync;
    logic             key_level;
    logic [CNT_W-1:0] hold_cnt;
    logic             hold_done;

    // new level has been stable long enough to be taken
    assign hold_done = (key_sync != key_level) &&
                       (hold_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            key_meta  <= 1'b0;
            key_sync  <= 1'b0;
            key_level <= 1'b0;
            hold_cnt  <= '0;
        end else begin
            key_meta <= key_i;
            key_sync <= key_meta;
            // any bounce back to the old level restarts the count
            if (key_sync == key_level) begin
                hold_cnt <= '0;
            end else if (hold_done) begin
                key_level <= key_sync;
                hold_cnt  <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    // only the rising edge of the accepted level is a press
    assign press_o = hold_done && key_sync;

    a_single_press : assert property (
        @(posedge clk) disable iff (!rstn_fpga) press_o |=> !press_o
    );

endmodule

/* src/run_ctrl.sv */
`timescale 1ns/1ps

module run_ctrl (
    input  logic                clk,
    input  logic                rstn_fpga,
    input  logic                press_i,
    input  logic                ebreak_i,
    output logic                exec_en_o,
    output logic                pc_clear_o,
    output cpu_pkg::run_state_e state_o
);

    import cpu_pkg::*;

    run_state_e state_q;
    run_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PROGRAM: begin
                if (press_i) begin
                    state_d = RUN;
                end
            end
            // presses are ignored while running
            RUN: begin
                if (ebreak_i) begin
                    state_d = HALT;
                end
            end
            HALT: begin
                if (press_i) begin
                    state_d = RUN;
                end
            end
            default: state_d = PROGRAM;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            state_q <= PROGRAM;
        end else begin
            state_q <= state_d;
        end
    end

    assign exec_en_o  = (state_q == RUN);
    assign pc_clear_o = (state_q == PROGRAM) && press_i;
    assign state_o    = state_q;

    // execution starts only from a press and stops only at an ebreak
    a_run_entry : assert property (
        @(posedge clk) disable iff (!rstn_fpga) $rose(exec_en_o) |-> $past(press_i)
    );
    a_run_exit : assert property (
        @(posedge clk) disable iff (!rstn_fpga) $fell(exec_en_o) |-> $past(ebreak_i)
    );

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rstn_fpga,
    input  cpu_pkg::prog_wr_t        prog_i,
    input  logic                     load_en_i,
    input  logic                     exec_en_i,
    input  logic                     pc_clear_i,
    input  cpu_pkg::ctrl_t           ctrl_i,
    input  logic [cpu_pkg::XLEN-1:0] imm_i,
    input  logic                     zero_i,
    output logic [cpu_pkg::XLEN-1:0] inst_o,
    output logic [cpu_pkg::XLEN-1:0] pc_o,
    output logic [cpu_pkg::XLEN-1:0] pc4_o
);

    import cpu_pkg::*;

    logic [XLEN-1:0] imem [2**IMEM_AW];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            taken;

    // load port, closed while the core runs
    always_ff @(posedge clk) begin
        if (prog_i.we && load_en_i) begin
            imem[prog_i.addr] <= prog_i.data;
        end
    end

    assign inst_o = imem[pc_q[IMEM_AW+1:2]];
    assign pc4_o  = pc_q + 32'd4;

    // zero means equal operands, bne inverts it
    assign taken = ctrl_i.jump || (ctrl_i.branch && (zero_i != ctrl_i.branch_ne));

    always_comb begin
        pc_next = pc4_o;
        if (ctrl_i.ebreak) begin
            pc_next = pc_q;
        end else if (taken) begin
            pc_next = pc_q + imm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            pc_q <= '0;
        end else if (pc_clear_i) begin
            pc_q <= '0;
        end else if (exec_en_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic [cpu_pkg::XLEN-1:0] inst_i,
    output cpu_pkg::ctrl_t           ctrl_o,
    output logic [cpu_pkg::XLEN-1:0] imm_o,
    output logic [4:0]               rs1_o,
    output logic [4:0]               rs2_o,
    output logic [4:0]               rd_o,
    output cpu_pkg::alu_op_e         alu_op_o
);

    import cpu_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_j_type;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];

    // -------------------------------------------------------------------------
    // immediates
    // -------------------------------------------------------------------------
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};

    // -------------------------------------------------------------------------
    // control, unsupported encodings fall out as no-ops
    // -------------------------------------------------------------------------
    always_comb begin
        ctrl_o = '0;
        imm_o  = imm_i_type;
        case (opcode)
            OP: begin
                ctrl_o.reg_write = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (inst_i[30]) begin
                            ctrl_o.alu_op = SUB;
                        end else begin
                            ctrl_o.alu_op = ADD;
                        end
                    end
                    3'b010:  ctrl_o.alu_op = SLT;
                    3'b100:  ctrl_o.alu_op = XOR;
                    3'b110:  ctrl_o.alu_op = OR;
                    3'b111:  ctrl_o.alu_op = AND;
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            // addi only
            OP_IMM: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = (funct3 == 3'b000);
            end
            LUI: begin
                imm_o              = imm_u_type;
                ctrl_o.alu_op      = PASS_B;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
            end
            // word accesses only
            LOAD: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_read    = (funct3 == 3'b010);
                ctrl_o.reg_write   = (funct3 == 3'b010);
            end
            STORE: begin
                imm_o              = imm_s_type;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = (funct3 == 3'b010);
            end
            BRANCH: begin
                imm_o            = imm_b_type;
                ctrl_o.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl_o.branch_ne = (funct3 == 3'b001);
            end
            JAL: begin
                imm_o            = imm_j_type;
                ctrl_o.jump      = 1'b1;
                ctrl_o.wb_pc4    = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            SYSTEM: ctrl_o.ebreak = (inst_i == EBREAK_INST);
            default: ;
        endcase
    end

    assign alu_op_o = ctrl_o.alu_op;

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rstn_fpga,
    input  logic                     we_i,
    input  logic [4:0]               rs1_i,
    input  logic [4:0]               rs2_i,
    input  logic [4:0]               rd_i,
    input  logic [cpu_pkg::XLEN-1:0] wdata_i,
    output logic [cpu_pkg::XLEN-1:0] rdata1_o,
    output logic [cpu_pkg::XLEN-1:0] rdata2_o
);

    import cpu_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::XLEN-1:0] a_i,
    input  logic [cpu_pkg::XLEN-1:0] b_i,
    input  cpu_pkg::alu_op_e         op_i,
    output logic [cpu_pkg::XLEN-1:0] result_o,
    output logic                     zero_o
);

    import cpu_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            XOR:     result_o = a_i ^ b_i;
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_signed};
            // lui puts the U immediate through here
            PASS_B:  result_o = b_i;
            default: result_o = '0;
        endcase
    end

    // compare flag for beq and bne
    assign zero_o = (a_i == b_i);

endmodule

/* src/mem_io.sv */
`timescale 1ns/1ps

module mem_io (
    input  logic                     clk,
    input  logic                     rstn_fpga,
    input  logic                     read_i,
    input  logic                     write_i,
    input  logic [cpu_pkg::XLEN-1:0] addr_i,
    input  logic [cpu_pkg::XLEN-1:0] wdata_i,
    input  logic [15:0]              switch_i,
    output logic [cpu_pkg::XLEN-1:0] rdata_o,
    output logic [15:0]              led_o
);

    import cpu_pkg::*;

    logic [XLEN-1:0]    dmem [2**DMEM_AW];
    logic [15:0]        sw_q;
    logic [15:0]        led_q;
    logic               is_mem;
    logic [DMEM_AW-1:0] word_addr;

    assign is_mem    = (addr_i < IO_BASE);
    assign word_addr = addr_i[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (write_i && is_mem) begin
            dmem[word_addr] <= wdata_i;
        end
    end

    // -------------------------------------------------------------------------
    // switch and LED registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            sw_q  <= '0;
            led_q <= '0;
        end else begin
            sw_q <= switch_i;
            if (write_i && (addr_i == LED_ADDR)) begin
                led_q <= wdata_i[15:0];
            end
        end
    end

    // unmapped I/O reads as zero
    always_comb begin
        rdata_o = '0;
        if (read_i) begin
            if (is_mem) begin
                rdata_o = dmem[word_addr];
            end else if (addr_i == SW_ADDR) begin
                rdata_o = {16'b0, sw_q};
            end
        end
    end

    assign led_o = led_q;

    a_no_rd_wr : assert property (
        @(posedge clk) disable iff (!rstn_fpga) !(read_i && write_i)
    );

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                 clk,
    input  logic                 rstn_fpga,
    input  logic                 conf_btn_i,
    input  cpu_pkg::prog_wr_t    prog_i,
    input  logic [15:0]          switch_i,
    output logic [15:0]          led_o,
    output cpu_pkg::cpu_status_t status_o
);

    import cpu_pkg::*;

    // -------------------------------------------------------------------------
    // nets
    // -------------------------------------------------------------------------
    logic            press;
    logic            exec_en;
    logic            pc_clear;
    run_state_e      state;
    logic            resume;
    logic            fetch_en;
    ctrl_t           ctrl;
    ctrl_t           fetch_ctrl;
    alu_op_e         alu_op;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            zero;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;

    // -------------------------------------------------------------------------
    // run control
    // -------------------------------------------------------------------------
    key_debounce u_conf_deb (
        .clk       (clk),
        .rstn_fpga (rstn_fpga),
        .key_i     (conf_btn_i),
        .press_o   (press)
    );

    run_ctrl u_run_ctrl (
        .clk        (clk),
        .rstn_fpga  (rstn_fpga),
        .press_i    (press),
        .ebreak_i   (ctrl.ebreak),
        .exec_en_o  (exec_en),
        .pc_clear_o (pc_clear),
        .state_o    (state)
    );

    // resuming steps the pc past the ebreak it stopped on
    assign resume   = (state == HALT) && press;
    assign fetch_en = exec_en || resume;

    always_comb begin
        fetch_ctrl        = ctrl;
        fetch_ctrl.ebreak = ctrl.ebreak && !resume;
    end

    // -------------------------------------------------------------------------
    // datapath
    // -------------------------------------------------------------------------
    fetch_unit u_fetch (
        .clk        (clk),
        .rstn_fpga  (rstn_fpga),
        .prog_i     (prog_i),
        .load_en_i  (state != RUN),
        .exec_en_i  (fetch_en),
        .pc_clear_i (pc_clear),
        .ctrl_i     (fetch_ctrl),
        .imm_i      (imm),
        .zero_i     (zero),
        .inst_o     (inst),
        .pc_o       (pc),
        .pc4_o      (pc4)
    );

    inst_decoder u_dec (
        .inst_i   (inst),
        .ctrl_o   (ctrl),
        .imm_o    (imm),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .rd_o     (rd),
        .alu_op_o (alu_op)
    );

    reg_file u_regs (
        .clk       (clk),
        .rstn_fpga (rstn_fpga),
        .we_i      (ctrl.reg_write && exec_en),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rd_i      (rd),
        .wdata_i   (wb_data),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rdata2;

    alu u_alu (
        .a_i      (rdata1),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    mem_io u_mem_io (
        .clk       (clk),
        .rstn_fpga (rstn_fpga),
        .read_i    (ctrl.mem_read && exec_en),
        .write_i   (ctrl.mem_write && exec_en),
        .addr_i    (alu_result),
        .wdata_i   (rdata2),
        .switch_i  (switch_i),
        .rdata_o   (load_data),
        .led_o     (led_o)
    );

    // write-back select
    always_comb begin
        if (ctrl.wb_pc4) begin
            wb_data = pc4;
        end else if (ctrl.mem_read) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_result;
        end
    end

    always_comb begin
        status_o.running = (state == RUN);
        status_o.halted  = (state == HALT);
        status_o.pc      = pc;
    end

endmodule

/* verification/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// ---------------------------------------------------------------------------
// instruction encoders
// ---------------------------------------------------------------------------
function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] lw_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] sw_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// funct3 000 is beq, 001 is bne
function automatic logic [31:0] branch_inst(input logic [2:0] funct3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] ebreak_inst();
    return 32'h0010_0073;
endfunction

// ---------------------------------------------------------------------------
// reference model state
// ---------------------------------------------------------------------------
logic [31:0] model_regs [32];
logic [31:0] model_mem  [256];
logic [31:0] model_prog [256];
logic [15:0] model_led;
logic [15:0] model_sw;
logic [31:0] model_pc;

task automatic reset_model(input logic [15:0] sw);
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_led = '0;
    model_pc  = '0;
    model_sw  = sw;
endtask

// runs from model_pc and stops with model_pc on the next ebreak
task automatic run_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    int          steps;
    steps = 0;
    while ((model_prog[model_pc[9:2]] != ebreak_inst()) && (steps < 10000)) begin
        ins     = model_prog[model_pc[9:2]];
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        rd      = ins[11:7];
        next_pc = model_pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                case (ins[14:12])
                    3'b000:  model_regs[rd] = ins[30] ? a - b : a + b;
                    3'b010:  model_regs[rd] = {31'b0, $signed(a) < $signed(b)};
                    3'b100:  model_regs[rd] = a ^ b;
                    3'b110:  model_regs[rd] = a | b;
                    3'b111:  model_regs[rd] = a & b;
                    default: ;
                endcase
            end
            7'b0010011: model_regs[rd] = a + {{20{ins[31]}}, ins[31:20]};
            7'b0110111: model_regs[rd] = {ins[31:12], 12'b0};
            // word load, switches sit at the bottom of the I/O page
            7'b0000011: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                if (addr < 32'h0000_F000) begin
                    model_regs[rd] = model_mem[addr[9:2]];
                end else if (addr == 32'h0000_F000) begin
                    model_regs[rd] = {16'b0, model_sw};
                end else begin
                    model_regs[rd] = '0;
                end
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (addr < 32'h0000_F000) begin
                    model_mem[addr[9:2]] = b;
                end else if (addr == 32'h0000_F004) begin
                    model_led = b[15:0];
                end
            end
            7'b1100011: begin
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    next_pc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                model_regs[rd] = model_pc + 32'd4;
                next_pc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        model_regs[0] = '0;
        model_pc      = next_pc;
        steps++;
    end
endtask

`endif

/* verification/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;

    import cpu_pkg::*;

    logic        clk = 1'b0;
    logic        rstn_fpga;
    logic        conf_btn;
    prog_wr_t    prog;
    logic [15:0] switches;
    logic [15:0] led;
    cpu_status_t status;
    int          prog_len;

    `include "cpu_model.svh"

    cpu_top dut (
        .clk        (clk),
        .rstn_fpga  (rstn_fpga),
        .conf_btn_i (conf_btn),
        .prog_i     (prog),
        .switch_i   (switches),
        .led_o      (led),
        .status_o   (status)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    function automatic cpu_status_t status_of(input logic running, input logic halted,
                                              input logic [XLEN-1:0] pc);
        cpu_status_t s;
        s.running = running;
        s.halted  = halted;
        s.pc      = pc;
        return s;
    endfunction

    task automatic check_led(input logic [15:0] expected);
        if (led !== expected) begin
            $display("FAIL at %0t: led_o is %h, expected %h", $time, led, expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_status(input cpu_status_t expected);
        if (status !== expected) begin
            $display("FAIL at %0t: status_o running %b halted %b pc %h, expected %b %b %h",
                     $time, status.running, status.halted, status.pc,
                     expected.running, expected.halted, expected.pc);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // drivers, all called on a falling edge
    // ------------------------------------------------------------------------
    task automatic apply_reset();
        @(negedge clk);
        rstn_fpga = 1'b0;
        repeat (4) @(negedge clk);
        rstn_fpga = 1'b1;
    endtask

    task automatic write_word(input logic [IMEM_AW-1:0] addr, input logic [XLEN-1:0] data);
        prog.we   = 1'b1;
        prog.addr = addr;
        prog.data = data;
        @(negedge clk);
        prog.we = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            write_word(IMEM_AW'(i), model_prog[i]);
        end
    endtask

    // release is held long enough for the next press to count
    task automatic press_key(input int hold);
        conf_btn = 1'b1;
        repeat (hold) @(negedge clk);
        conf_btn = 1'b0;
        repeat (20) @(negedge clk);
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!status.halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!status.halted) begin
            $display("timeout: the processor did not halt within 2000 cycles");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // program generation
    // ------------------------------------------------------------------------
    function automatic logic [4:0] random_rd();
        return 5'($urandom_range(30, 1));
    endfunction

    function automatic logic [4:0] random_rs();
        return 5'($urandom_range(31, 0));
    endfunction

    function automatic logic [31:0] random_alu_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] ins;
        rd  = random_rd();
        rs1 = random_rs();
        rs2 = random_rs();
        case ($urandom_range(7, 0))
            0:       ins = r_type(7'h00, 3'b000, rd, rs1, rs2);
            1:       ins = r_type(7'h20, 3'b000, rd, rs1, rs2);
            2:       ins = r_type(7'h00, 3'b111, rd, rs1, rs2);
            3:       ins = r_type(7'h00, 3'b110, rd, rs1, rs2);
            4:       ins = r_type(7'h00, 3'b100, rd, rs1, rs2);
            5:       ins = r_type(7'h00, 3'b010, rd, rs1, rs2);
            6:       ins = addi_inst(rd, rs1, 12'($urandom()));
            default: ins = lui_inst(rd, 20'($urandom()));
        endcase
        return ins;
    endfunction

    // x31 holds the I/O base and is never a random destination
    task automatic build_random_program(input bit mem_ops);
        int stored [$];
        int choice;
        int k;
        model_prog[0] = lui_inst(5'd31, 20'h0000F);
        for (int idx = 1; idx < 15; idx++) begin
            choice = mem_ops ? $urandom_range(3, 0) : 0;
            if (choice == 1) begin
                k = $urandom_range(63, 0);
                stored.push_back(k);
                model_prog[idx] = sw_inst(random_rs(), 5'd0, 12'(k * 4));
            end else if ((choice == 2) && (stored.size() > 0)) begin
                k = stored[$urandom_range(stored.size() - 1, 0)];
                model_prog[idx] = lw_inst(random_rd(), 5'd0, 12'(k * 4));
            end else if (choice == 3) begin
                model_prog[idx] = lw_inst(random_rd(), 5'd31, 12'd0);
            end else begin
                model_prog[idx] = random_alu_inst();
            end
        end
        model_prog[15] = sw_inst(random_rd(), 5'd31, 12'd4);
        model_prog[16] = ebreak_inst();
        prog_len = 17;
    endtask

    task automatic build_loop_program();
        int count;
        int step;
        count = $urandom_range(30, 1);
        step  = $urandom_range(50, 1);
        model_prog[0]  = lui_inst(5'd31, 20'h0000F);
        model_prog[1]  = addi_inst(5'd1, 5'd0, 12'(count));
        model_prog[2]  = addi_inst(5'd2, 5'd0, 12'd0);
        model_prog[3]  = addi_inst(5'd2, 5'd2, 12'(step));
        model_prog[4]  = addi_inst(5'd1, 5'd1, 12'hFFF);
        model_prog[5]  = branch_inst(3'b001, 5'd1, 5'd0, 13'h1FF8);
        model_prog[6]  = branch_inst(3'b000, 5'd2, 5'd2, 13'd8);
        model_prog[7]  = addi_inst(5'd2, 5'd0, 12'h7FF);
        model_prog[8]  = branch_inst(3'b000, 5'd1, 5'd2, 13'd8);
        model_prog[9]  = addi_inst(5'd2, 5'd2, 12'd3);
        model_prog[10] = jal_inst(5'd5, 21'd8);
        model_prog[11] = addi_inst(5'd2, 5'd0, 12'd0);
        model_prog[12] = r_type(7'h00, 3'b000, 5'd6, 5'd2, 5'd5);
        model_prog[13] = sw_inst(5'd6, 5'd31, 12'd4);
        model_prog[14] = ebreak_inst();
        prog_len = 15;
    endtask

    // second half spins long enough for a load-port write to land mid run
    task automatic build_two_stop_program();
        model_prog[0]  = lui_inst(5'd31, 20'h0000F);
        model_prog[1]  = addi_inst(5'd1, 5'd0, 12'($urandom_range(2000, 1)));
        model_prog[2]  = sw_inst(5'd1, 5'd31, 12'd4);
        model_prog[3]  = ebreak_inst();
        model_prog[4]  = addi_inst(5'd2, 5'd0, 12'd100);
        model_prog[5]  = addi_inst(5'd3, 5'd0, 12'($urandom_range(1000, 1)));
        model_prog[6]  = addi_inst(5'd3, 5'd3, 12'd1);
        model_prog[7]  = addi_inst(5'd2, 5'd2, 12'hFFF);
        model_prog[8]  = branch_inst(3'b001, 5'd2, 5'd0, 13'h1FF8);
        model_prog[9]  = sw_inst(5'd3, 5'd31, 12'd4);
        model_prog[10] = ebreak_inst();
        prog_len = 11;
    endtask

    task automatic start_program();
        apply_reset();
        reset_model(switches);
        load_program();
        press_key(20);
    endtask

    task automatic check_halt();
        wait_halted();
        run_model();
        check_led(model_led);
        check_status(status_of(1'b0, 1'b1, model_pc));
    endtask

    // ------------------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h6731e06a));
        rstn_fpga = 1'b0;
        conf_btn  = 1'b0;
        prog      = '0;
        switches  = '0;
        apply_reset();
        check_status(status_of(1'b0, 1'b0, 32'd0));
        check_led(16'h0000);

        // jump to self so running stays up after the full press
        model_prog[0] = jal_inst(5'd0, 21'd0);
        prog_len = 1;
        load_program();
        press_key(3);
        check_status(status_of(1'b0, 1'b0, 32'd0));
        press_key(20);
        check_status(status_of(1'b1, 1'b0, 32'd0));

        repeat (20) begin
            build_random_program(1'b0);
            start_program();
            check_halt();
        end

        repeat (10) begin
            switches = 16'($urandom());
            build_random_program(1'b1);
            start_program();
            check_halt();
        end

        repeat (5) begin
            build_loop_program();
            start_program();
            check_halt();
        end

        build_two_stop_program();
        start_program();
        check_halt();
        model_pc = model_pc + 32'd4;
        press_key(20);
        if (!status.running) begin
            $display("the processor was not running when the load-port write was tried");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        write_word(IMEM_AW'(9), sw_inst(5'd0, 5'd31, 12'd4));
        check_halt();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
src/cpu_pkg.sv
src/key_debounce.sv
src/run_ctrl.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/reg_file.sv
src/alu.sv
src/mem_io.sv
src/cpu_top.sv
+incdir+verification
verification/tb_cpu_top.sv
